// ==== sim/pu_stimulus.txt ====
# name op adr data attr exp_data exp_attr, numbers in hex
# wr sends data with tag attr, rd compares the read data and tag with exp_data and exp_attr
rst_mult_res    rd 4 00000000 0 00000000 0
rst_acc_res     rd 5 00000000 0 00000000 0
opnd_read       rd 1 00000000 0 00000000 0
res_write       wr 4 12345678 1 00000000 0
res_write_chk   rd 4 00000000 0 00000000 0
mul_a_pos       wr 0 00000007 0 00000000 0
mul_b_neg       wr 1 fffffffd 0 00000000 0
mul_pos_neg     rd 4 00000000 0 ffffffeb 0
mul_a_min       wr 0 ffff8000 0 00000000 0
mul_b_max       wr 1 00007fff 0 00000000 0
mul_min_max     rd 4 00000000 0 c0008000 0
rng_a_mixed     wr 0 00010003 0 00000000 0
rng_b_small     wr 1 00000002 0 00000000 0
rng_a_bad       rd 4 00000000 0 00000006 1
rng_a_edge      wr 0 00008000 0 00000000 0
rng_b_mixed     wr 1 ffff0004 0 00000000 0
rng_both_bad    rd 4 00000000 0 fffe0000 1
inv_a_tagged    wr 0 00000004 1 00000000 0
inv_b_clean     wr 1 00000003 0 00000000 0
inv_mult        rd 4 00000000 0 0000000c 1
inv_a_clean     wr 0 00000004 0 00000000 0
inv_b_again     wr 1 00000003 0 00000000 0
inv_mult_clear  rd 4 00000000 0 0000000c 0
acc_load        wr 2 0000000a 0 00000000 0
acc_add_pos     wr 3 00000014 0 00000000 0
acc_add_neg     wr 3 fffffffb 0 00000000 0
acc_sum         rd 5 00000000 0 00000019 0
acc_load_big    wr 2 7ffffff0 0 00000000 0
acc_add_ovf     wr 3 00000020 0 00000000 0
acc_ovf         rd 5 00000000 0 80000010 1
acc_add_more    wr 3 00000001 0 00000000 0
acc_sticky      rd 5 00000000 0 80000011 1
mult_hold       rd 4 00000000 0 0000000c 0
acc_reload      wr 2 00000005 0 00000000 0
acc_cleared     rd 5 00000000 0 00000005 0
acc_add_tagged  wr 3 00000002 1 00000000 0
acc_inv_tag     rd 5 00000000 0 00000007 1
opnd_read_acc   rd 2 00000000 0 00000000 0

// ==== filelist.f ====
hw/pu_pkg.sv
hw/pu_bus_decode.sv
hw/pu_mult.sv
hw/pu_accum.sv
hw/pu_result_bus.sv
hw/pu_top.sv
sim/tb_clock.sv
sim/pu_checker.sv
sim/tb_pu_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log for the pass message

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -j 0 \
  --top-module tb_pu_top \
  -Mdir "$build_dir" \
  -o tb_pu_top \
  -f filelist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/tb_pu_top" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "SIMULATION PASSED" "$log_file"; then
  exit 0
else
  echo "pass message not found in $log_file"
  exit 1
fi

// ==== sim/tb_pu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_pu_top
  import pu_pkg::*;
();

  localparam int max_ops = 64;
  localparam int name_bytes = 20;
  localparam int drive_delay = 1;

  logic                     clk;
  logic                     rst;
  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     wb_we;
  logic [pu_adr_width-1:0]  wb_adr;
  logic [pu_data_width-1:0] wb_dat_w;
  logic [pu_attr_width:0]   wb_tgd_w;
  logic                     wb_ack;
  logic [pu_data_width-1:0] wb_dat_r;
  logic [pu_attr_width:0]   wb_tgd_r;

  logic [8*name_bytes-1:0]  op_name [max_ops];
  logic                     op_rd [max_ops];
  logic [pu_adr_width-1:0]  op_adr [max_ops];
  logic [pu_data_width-1:0] op_data [max_ops];
  logic [pu_attr_width:0]   op_attr [max_ops];
  pu_out_t                  op_exp [max_ops];

  logic [8*name_bytes-1:0]  exp_name;
  pu_out_t                  exp_out;
  int                       n_ops;
  int                       tb_errors;
  int                       cycle_count;
  int                       cycle_limit;
  int                       checks_passed;
  int                       checks_failed;
  int                       ack_count;

  tb_clock #(
    .period_ns    (8),
    .reset_cycles (4)
  ) u_clock (
    .clk (clk),
    .rst (rst)
  );

  pu_top #(
    .invalid_bit (0)
  ) DUT (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_tgd_w (wb_tgd_w),
    .wb_ack   (wb_ack),
    .wb_dat_r (wb_dat_r),
    .wb_tgd_r (wb_tgd_r)
  );

  pu_checker #(
    .name_bytes (name_bytes)
  ) u_checker (
    .clk           (clk),
    .rst           (rst),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_ack        (wb_ack),
    .wb_dat_r      (wb_dat_r),
    .wb_tgd_r      (wb_tgd_r),
    .exp_name      (exp_name),
    .expected      (exp_out),
    .checks_passed (checks_passed),
    .checks_failed (checks_failed),
    .ack_count     (ack_count)
  );

  task automatic load_stimulus();
    int                      fd;
    int                      code;
    int                      ch;
    logic [8*name_bytes-1:0] tok;
    logic [8*name_bytes-1:0] hash_tok;
    logic [15:0]             op;
    logic [31:0]             adr_v;
    logic [31:0]             dat_v;
    logic [31:0]             attr_v;
    logic [31:0]             exp_d_v;
    logic [31:0]             exp_a_v;
    hash_tok = '0;
    hash_tok[7:0] = 8'h23; // a lone # token opens a comment line
    fd = $fopen("sim/pu_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file sim/pu_stimulus.txt");
      tb_errors++;
      return;
    end
    code = $fscanf(fd, "%s", tok);
    while (code == 1) begin
      if (tok == hash_tok) begin
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else begin
        code = $fscanf(fd, "%s %h %h %h %h %h", op, adr_v, dat_v, attr_v, exp_d_v, exp_a_v);
        if (code != 6 || (op != "rd" && op != "wr") || n_ops >= max_ops) begin
          $display("the stimulus file has a bad line after operation %0d", n_ops);
          tb_errors++;
          break;
        end
        op_name[n_ops] = tok;
        op_rd[n_ops] = (op == "rd");
        op_adr[n_ops] = adr_v[pu_adr_width-1:0];
        op_data[n_ops] = dat_v;
        op_attr[n_ops] = attr_v[pu_attr_width:0];
        op_exp[n_ops].data = exp_d_v;
        op_exp[n_ops].attr = exp_a_v[pu_attr_width:0];
        n_ops++;
      end
      code = $fscanf(fd, "%s", tok);
    end
    $fclose(fd);
    if (n_ops == 0) begin
      $display("the stimulus file holds no operations");
      tb_errors++;
    end
  endtask

  // one Wishbone classic cycle, held until ack and followed by two idle cycles
  task automatic run_op(input int i);
    #(drive_delay);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = ~op_rd[i];
    wb_adr = op_adr[i];
    wb_dat_w = op_data[i];
    wb_tgd_w = op_attr[i];
    if (op_rd[i]) begin
      exp_name = op_name[i];
      exp_out = op_exp[i];
    end
    @(posedge clk);
    while (!wb_ack) begin
      @(posedge clk);
    end
    #(drive_delay);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    repeat (2) @(posedge clk);
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("the run did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    wb_tgd_w = '0;
    exp_name = '0;
    exp_out = '0;
    n_ops = 0;
    tb_errors = 0;
    cycle_count = 0;
    cycle_limit = 0;
    load_stimulus();
    cycle_limit = 8 * n_ops + 50; // each operation needs about five cycles
    wait (rst === 1'b0);
    @(posedge clk);
    for (int i = 0; i < n_ops; i++) begin
      run_op(i);
    end
    repeat (2) @(posedge clk);
    if (ack_count != n_ops) begin
      $display("%0d transactions were run but %0d acks were seen", n_ops, ack_count);
      tb_errors++;
    end
    $display("checks passed %0d, checks failed %0d, other errors %0d",
             checks_passed, checks_failed, tb_errors);
    if (checks_failed == 0 && tb_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/pu_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module pu_checker
  import pu_pkg::*;
#(
  parameter int name_bytes = 20
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic                     wb_ack,
  input  logic [pu_data_width-1:0] wb_dat_r,
  input  logic [pu_attr_width:0]   wb_tgd_r,
  input  logic [8*name_bytes-1:0]  exp_name,
  input  pu_out_t                  expected,
  output int                       checks_passed,
  output int                       checks_failed,
  output int                       ack_count
);

  // read data is registered, so the values before the edge belong to the ack cycle
  always @(posedge clk) begin
    if (rst) begin
      checks_passed = 0;
      checks_failed = 0;
      ack_count = 0;
    end else if (wb_ack) begin
      ack_count++;
      if (!(wb_cyc && wb_stb)) begin
        $display("an ack arrived while no request was on the bus");
        checks_failed++;
      end else if (!wb_we) begin
        if (wb_dat_r === expected.data && wb_tgd_r === expected.attr) begin
          $display("[PASS] %0s: data %h attr %h", exp_name, wb_dat_r, wb_tgd_r);
          checks_passed++;
        end else begin
          $display("[ERROR] %0s: expected data %h attr %h, actual data %h attr %h",
                   exp_name, expected.data, expected.attr, wb_dat_r, wb_tgd_r);
          checks_failed++;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
  parameter int period_ns = 8,
  parameter int reset_cycles = 4
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1 rst = 1'b0; // released just after an edge like every other input
  end

endmodule

`default_nettype wire

// ==== hw/pu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module pu_top
  import pu_pkg::*;
#(
  parameter int invalid_bit = 0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [pu_adr_width-1:0]  wb_adr,
  input  logic [pu_data_width-1:0] wb_dat_w,
  input  logic [pu_attr_width:0]   wb_tgd_w,
  output logic                     wb_ack,
  output logic [pu_data_width-1:0] wb_dat_r,
  output logic [pu_attr_width:0]   wb_tgd_r
);

  pu_wr_t  mult_wr;
  pu_wr_t  acc_wr;
  logic    mult_oe;
  logic    acc_oe;
  pu_out_t mult_out;
  pu_out_t acc_out;

  pu_bus_decode u_decode (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_tgd_w (wb_tgd_w),
    .wb_ack   (wb_ack),
    .mult_wr  (mult_wr),
    .acc_wr   (acc_wr),
    .mult_oe  (mult_oe),
    .acc_oe   (acc_oe)
  );

  pu_mult #(
    .invalid_bit (invalid_bit)
  ) u_mult (
    .clk      (clk),
    .rst      (rst),
    .mult_wr  (mult_wr),
    .oe       (mult_oe),
    .mult_out (mult_out)
  );

  pu_accum #(
    .invalid_bit (invalid_bit)
  ) u_accum (
    .clk     (clk),
    .rst     (rst),
    .acc_wr  (acc_wr),
    .oe      (acc_oe),
    .acc_out (acc_out)
  );

  pu_result_bus u_result (
    .clk      (clk),
    .rst      (rst),
    .mult_out (mult_out),
    .acc_out  (acc_out),
    .wb_dat_r (wb_dat_r),
    .wb_tgd_r (wb_tgd_r)
  );

endmodule

`default_nettype wire

// ==== hw/pu_result_bus.sv ====
`timescale 1ns/10ps
`default_nettype none

module pu_result_bus
  import pu_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  pu_out_t                  mult_out,
  input  pu_out_t                  acc_out,
  output logic [pu_data_width-1:0] wb_dat_r,
  output logic [pu_attr_width:0]   wb_tgd_r
);

  pu_out_t merged;

  // disabled PUs drive zeros, so at most one term is nonzero
  assign merged = mult_out | acc_out;

  // sampled every cycle, the value is meaningful in the ack cycle after an enable
  // and reads without an enable come back as zero
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_dat_r <= '0;
      wb_tgd_r <= '0;
    end else begin
      wb_dat_r <= merged.data;
      wb_tgd_r <= merged.attr;
    end
  end

endmodule

`default_nettype wire

// ==== hw/pu_accum.sv ====
`timescale 1ns/10ps
`default_nettype none

module pu_accum
  import pu_pkg::*;
#(
  parameter int invalid_bit = 0
) (
  input  logic    clk,
  input  logic    rst,
  input  pu_wr_t  acc_wr,
  input  logic    oe,
  output pu_out_t acc_out
);

  localparam int msb = pu_data_width - 1;

  logic [pu_data_width-1:0] acc_data;
  logic                     acc_inv;  // sticky until the next load
  logic [pu_data_width-1:0] sum;
  logic                     ovf;
  logic [pu_attr_width:0]   flag_vec;

  assign sum = acc_data + acc_wr.data; // wraps at 32 bits

  // signed overflow when both addends agree in sign and the sum does not
  assign ovf = (acc_data[msb] == acc_wr.data[msb]) && (sum[msb] != acc_data[msb]);

  always_ff @(posedge clk) begin
    if (rst) begin
      acc_data <= '0;
      acc_inv <= 1'b0;
    end else if (acc_wr.wr) begin
      if (acc_wr.sel) begin
        acc_data <= sum;
        acc_inv <= acc_inv | acc_wr.attr[invalid_bit] | ovf;
      end else begin
        acc_data <= acc_wr.data; // load drops any earlier flag
        acc_inv <= acc_wr.attr[invalid_bit];
      end
    end
  end

  always_comb begin
    flag_vec = '0;
    flag_vec[invalid_bit] = acc_inv;
  end

  assign acc_out = oe ? pu_out_t'{data: acc_data, attr: flag_vec} : '0;

endmodule

`default_nettype wire

// ==== hw/pu_mult.sv ====
`timescale 1ns/10ps
`default_nettype none

module pu_mult
  import pu_pkg::*;
#(
  parameter int invalid_bit = 0
) (
  input  logic    clk,
  input  logic    rst,
  input  pu_wr_t  mult_wr,
  input  logic    oe,
  output pu_out_t mult_out
);

  localparam int half_width = pu_data_width / 2;

  logic [pu_data_width-1:0]        opnd_a;
  logic [pu_data_width-1:0]        opnd_b;
  logic                            inv_a;
  logic                            inv_b;
  logic                            chk_go;  // B was taken at the last edge
  logic                            cap_go;  // range check is in chk_inv
  logic                            chk_inv;
  logic signed [half_width-1:0]    low_a;
  logic signed [half_width-1:0]    low_b;
  logic signed [pu_data_width-1:0] product;
  logic [pu_data_width-1:0]        res_data;
  logic                            res_inv;
  logic [pu_attr_width:0]          flag_vec;

  // true unless bits 31 down to 15 are a plain sign extension
  function automatic logic out_of_range(input logic [pu_data_width-1:0] v);
    logic [pu_data_width-half_width:0] hi;
    hi = v[pu_data_width-1:half_width-1];
    return !((hi == '0) || (hi == '1));
  endfunction

  always_ff @(posedge clk) begin
    if (mult_wr.wr) begin
      if (mult_wr.sel) begin
        opnd_b <= mult_wr.data;
        inv_b <= mult_wr.attr[invalid_bit];
      end else begin
        opnd_a <= mult_wr.data;
        inv_a <= mult_wr.attr[invalid_bit];
      end
    end
  end

  assign low_a = opnd_a[half_width-1:0];
  assign low_b = opnd_b[half_width-1:0];

  // both halves are sign extended to full width before the multiply
  assign product = pu_data_width'(low_a) * pu_data_width'(low_b);

  // writing B starts the two cycle pipeline, writing A alone starts nothing
  always_ff @(posedge clk) begin
    if (rst) begin
      chk_go <= 1'b0;
      cap_go <= 1'b0;
      chk_inv <= 1'b0;
      res_data <= '0;
      res_inv <= 1'b0;
    end else begin
      chk_go <= mult_wr.wr & mult_wr.sel;
      cap_go <= chk_go;
      if (chk_go) begin
        chk_inv <= out_of_range(opnd_a) | out_of_range(opnd_b) | inv_a | inv_b;
      end
      if (cap_go) begin
        res_data <= product; // low halves only, even when flagged
        res_inv <= chk_inv;
      end
    end
  end

  always_comb begin
    flag_vec = '0;
    flag_vec[invalid_bit] = res_inv;
  end

  assign mult_out = oe ? pu_out_t'{data: res_data, attr: flag_vec} : '0;

endmodule

`default_nettype wire

// ==== hw/pu_bus_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module pu_bus_decode
  import pu_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [pu_adr_width-1:0]  wb_adr,
  input  logic [pu_data_width-1:0] wb_dat_w,
  input  logic [pu_attr_width:0]   wb_tgd_w,
  output logic                     wb_ack,
  output pu_wr_t                   mult_wr,
  output pu_wr_t                   acc_wr,
  output logic                     mult_oe,
  output logic                     acc_oe
);

  logic                     pending; // request already seen in the previous cycle
  logic                     start;
  logic                     hit_mult;
  logic                     hit_acc;
  logic                     mult_wr_q;
  logic                     acc_wr_q;
  logic                     sel_q;
  logic [pu_data_width-1:0] data_q;
  logic [pu_attr_width:0]   attr_q;

  assign start = wb_cyc & wb_stb & ~pending; // first cycle of a new request only
  assign hit_mult = (wb_adr == adr_mult_a) || (wb_adr == adr_mult_b);
  assign hit_acc = (wb_adr == adr_acc_load) || (wb_adr == adr_acc_add);

  // enables lead ack by one cycle so the result bus can register the merged value
  assign mult_oe = start & ~wb_we & (wb_adr == adr_mult_res);
  assign acc_oe = start & ~wb_we & (wb_adr == adr_acc_res);

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
      wb_ack <= 1'b0;
      mult_wr_q <= 1'b0;
      acc_wr_q <= 1'b0;
    end else begin
      pending <= wb_cyc & wb_stb; // host must go idle for a cycle to rearm
      wb_ack <= start;
      mult_wr_q <= start & wb_we & hit_mult;
      acc_wr_q <= start & wb_we & hit_acc; // result addresses are never written
    end
  end

  // payload is shared by both PUs, only the strobe tells them apart
  always_ff @(posedge clk) begin
    if (start && wb_we) begin
      sel_q <= wb_adr[0];
      data_q <= wb_dat_w;
      attr_q <= wb_tgd_w;
    end
  end

  assign mult_wr = pu_wr_t'{
    wr:   mult_wr_q,
    sel:  sel_q,
    data: data_q,
    attr: attr_q
  };

  assign acc_wr = pu_wr_t'{
    wr:   acc_wr_q,
    sel:  sel_q,
    data: data_q,
    attr: attr_q
  };

endmodule

`default_nettype wire

// ==== hw/pu_pkg.sv ====
`default_nettype none

package pu_pkg;

  localparam int pu_data_width = 32;
  localparam int pu_attr_width = 4; // attr vectors are one bit wider than this
  localparam int pu_adr_width = 3;

  // word addresses seen by the host
  localparam logic [pu_adr_width-1:0] adr_mult_a = 3'd0;
  localparam logic [pu_adr_width-1:0] adr_mult_b = 3'd1;
  localparam logic [pu_adr_width-1:0] adr_acc_load = 3'd2;
  localparam logic [pu_adr_width-1:0] adr_acc_add = 3'd3;
  localparam logic [pu_adr_width-1:0] adr_mult_res = 3'd4;
  localparam logic [pu_adr_width-1:0] adr_acc_res = 3'd5;

  // one write request towards a PU
  typedef struct packed {
    logic                     wr;   // single cycle strobe
    logic                     sel;  // operand or operation select
    logic [pu_data_width-1:0] data;
    logic [pu_attr_width:0]   attr;
  } pu_wr_t;

  // a PU output, all zeros while its enable is low so outputs merge by OR
  typedef struct packed {
    logic [pu_data_width-1:0] data;
    logic [pu_attr_width:0]   attr;
  } pu_out_t;

endpackage

`default_nettype wire
